// ==== hw/bit_timer.sv ====
// Bit period counter, held at zero while run is low
// tick and mid are registered one-cycle strobes
`timescale 1ns/1ns
`default_nettype none

module bit_timer (
    input  wire  sys_clk,
    input  wire  sys_rst_n,
    input  wire  run,
    output logic tick,
    output logic mid
);

    // Position inside the current bit
    uart_echo_pkg::timer_cnt_t cnt;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
            mid  <= 1'b0;
        end else if (!run) begin
            // Stopped, restart phase from zero
            cnt  <= '0;
            tick <= 1'b0;
            mid  <= 1'b0;
        end else begin
            // Strobes land BIT_CYCLES and HALF_CYCLES after run rises
            tick <= (cnt == uart_echo_pkg::BIT_LAST);
            mid  <= (cnt == uart_echo_pkg::MID_LAST);
            if (cnt == uart_echo_pkg::BIT_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_buffer.sv ====
// Line memory of LINE_MAX bytes, filled in order from address 0
// Writes beyond a full line are dropped
// Read data arrives one cycle after rd_addr
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire                             sys_clk,
    input  wire                             sys_rst_n,
    input  wire uart_echo_pkg::line_wr_t    line_wr,
    input  wire uart_echo_pkg::line_addr_t  rd_addr,
    output uart_echo_pkg::byte_t            rd_data,
    output uart_echo_pkg::line_len_t        line_len
);

    uart_echo_pkg::byte_t      mem [uart_echo_pkg::LINE_MAX];
    // Next free slot, equals the byte count
    uart_echo_pkg::line_len_t  wr_ptr;
    logic                      wr_ok;

    // Room left and no clear pending
    assign wr_ok = line_wr.wr_en && !line_wr.clear &&
                   (wr_ptr != uart_echo_pkg::LINE_FULL);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
        end else if (line_wr.clear) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Storage and registered read port
    always_ff @(posedge sys_clk) begin
        if (wr_ok) begin
            mem[wr_ptr[6:0]] <= line_wr.data;
        end
        rd_data <= mem[rd_addr];
    end

    // count also tells the FSM when the line is full
    assign line_len = wr_ptr;

endmodule

`default_nettype wire

// ==== hw/line_echo_fsm.sv ====
// Collects a line and echoes it with CR LF
// A line closes on GAP_BITS idle bit times or at LINE_MAX bytes
// Bytes that arrive during an echo are dropped
`timescale 1ns/1ns
`default_nettype none

module line_echo_fsm (
    input  wire                              sys_clk,
    input  wire                              sys_rst_n,
    input  wire                              rx_valid,
    input  wire uart_echo_pkg::rx_byte_t     rx_byte,
    input  wire uart_echo_pkg::line_len_t    line_len,
    input  wire uart_echo_pkg::byte_t        rd_data,
    input  wire                              tx_busy,
    output uart_echo_pkg::line_wr_t          line_wr,
    output uart_echo_pkg::line_addr_t        rd_addr,
    output logic                             tx_start,
    output uart_echo_pkg::byte_t             tx_data,
    output uart_echo_pkg::byte_t             rx_data
);

    uart_echo_pkg::echo_state_t state;
    uart_echo_pkg::gap_cnt_t    gap_cnt;
    logic gap_run;
    logic gap_tick;
    logic accept;
    logic tx_busy_d;
    logic tx_done;
    // CR or LF frame already started
    logic tx_sent;

    // Good byte while the line is open
    assign accept = rx_valid && !rx_byte.frame_err &&
                    ((state == uart_echo_pkg::ST_IDLE) ||
                     (state == uart_echo_pkg::ST_COLLECT &&
                      line_len != uart_echo_pkg::LINE_FULL));

    // Any received frame restarts the gap phase
    assign gap_run = (state == uart_echo_pkg::ST_COLLECT) && !rx_valid;

    // Falling busy ends each echoed frame
    assign tx_done = tx_busy_d && !tx_busy;

    bit_timer ins_gap_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .run       (gap_run),
        .tick      (gap_tick),
        .mid       ()
    );

    // Idle bit times since the last frame, saturating
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n || !gap_run) begin
            gap_cnt <= '0;
        end else if (gap_tick && gap_cnt != uart_echo_pkg::GAP_DONE) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state     <= uart_echo_pkg::ST_IDLE;
            line_wr   <= '0;
            rd_addr   <= '0;
            tx_start  <= 1'b0;
            tx_data   <= '0;
            rx_data   <= '0;
            tx_busy_d <= 1'b0;
            tx_sent   <= 1'b0;
        end else begin
            // Strobes default low
            line_wr   <= '0;
            tx_start  <= 1'b0;
            tx_busy_d <= tx_busy;
            if (accept) begin
                line_wr.wr_en <= 1'b1;
                line_wr.data  <= rx_byte.data;
                rx_data       <= rx_byte.data;
            end
            case (state)
                uart_echo_pkg::ST_IDLE: begin
                    if (accept) begin
                        state <= uart_echo_pkg::ST_COLLECT;
                    end
                end
                uart_echo_pkg::ST_COLLECT: begin
                    // Line end, by gap or full buffer
                    if (gap_cnt == uart_echo_pkg::GAP_DONE ||
                        line_len == uart_echo_pkg::LINE_FULL) begin
                        rd_addr <= '0;
                        state   <= uart_echo_pkg::ST_READ;
                    end
                end
                uart_echo_pkg::ST_READ: begin
                    // rd_data valid next cycle
                    state <= uart_echo_pkg::ST_SEND;
                end
                uart_echo_pkg::ST_SEND: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        tx_data  <= rd_data;
                        state    <= uart_echo_pkg::ST_WAIT;
                    end
                end
                uart_echo_pkg::ST_WAIT: begin
                    if (tx_done) begin
                        if (uart_echo_pkg::line_len_t'(rd_addr) + 8'd1 == line_len) begin
                            state <= uart_echo_pkg::ST_CR;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            state   <= uart_echo_pkg::ST_READ;
                        end
                    end
                end
                uart_echo_pkg::ST_CR: begin
                    if (!tx_sent && !tx_busy) begin
                        tx_start <= 1'b1;
                        tx_data  <= uart_echo_pkg::CR_CHAR;
                        tx_sent  <= 1'b1;
                    end else if (tx_sent && tx_done) begin
                        tx_sent <= 1'b0;
                        state   <= uart_echo_pkg::ST_LF;
                    end
                end
                uart_echo_pkg::ST_LF: begin
                    if (!tx_sent && !tx_busy) begin
                        tx_start <= 1'b1;
                        tx_data  <= uart_echo_pkg::LF_CHAR;
                        tx_sent  <= 1'b1;
                    end else if (tx_sent && tx_done) begin
                        // Echo finished, empty the line
                        tx_sent       <= 1'b0;
                        line_wr.clear <= 1'b1;
                        state         <= uart_echo_pkg::ST_IDLE;
                    end
                end
                default: state <= uart_echo_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_echo_pkg.sv ====
// Constants and types shared by the UART echo design
// Fixed 50 MHz clock and 115200 baud, 8N1 frames only
// BIT_CYCLES must fit in timer_cnt_t if the rates change
`default_nettype none

package uart_echo_pkg;

    // Clock and serial rate
    localparam int CLK_HZ      = 50_000_000;
    localparam int BAUD_RATE   = 115_200;
    // 434 clocks per bit at these rates
    localparam int BIT_CYCLES  = CLK_HZ / BAUD_RATE;
    localparam int HALF_CYCLES = BIT_CYCLES / 2;

    // Line limits
    localparam int LINE_MAX = 128;
    // Idle bit times that close a line
    localparam int GAP_BITS = 20;

    // Widths with a meaning
    typedef logic [7:0] byte_t;
    // 0 to 128, so one bit wider than the address
    typedef logic [7:0] line_len_t;
    typedef logic [6:0] line_addr_t;
    typedef logic [8:0] timer_cnt_t;
    typedef logic [4:0] gap_cnt_t;
    // Frame bit index, start = 0, stop = 9
    typedef logic [3:0] bit_idx_t;

    // Compare values at the typed widths
    localparam timer_cnt_t BIT_LAST  = timer_cnt_t'(BIT_CYCLES - 1);
    localparam timer_cnt_t MID_LAST  = timer_cnt_t'(HALF_CYCLES - 1);
    localparam line_len_t  LINE_FULL = line_len_t'(LINE_MAX);
    localparam gap_cnt_t   GAP_DONE  = gap_cnt_t'(GAP_BITS);
    localparam bit_idx_t   STOP_IDX  = 4'd9;

    // Line terminator sent after every echo
    localparam byte_t CR_CHAR = 8'h0D;
    localparam byte_t LF_CHAR = 8'h0A;

    // Receiver result
    typedef struct packed {
        byte_t data;
        logic  frame_err;
    } rx_byte_t;

    // Write command into the line memory
    typedef struct packed {
        logic  wr_en;
        byte_t data;
        logic  clear;
    } line_wr_t;

    // Echo controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_READ,
        ST_SEND,
        ST_WAIT,
        ST_CR,
        ST_LF
    } echo_state_t;

endpackage

`default_nettype wire

// ==== hw/uart_echo_top.sv ====
// UART line echo, single clock domain
// Fixed baud from the package, no parity, no flow control
// rx_data holds the last good byte of a line
`timescale 1ns/1ns
`default_nettype none

module uart_echo_top (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    input  wire                        uart_rx_port,
    output wire                        uart_tx_port,
    output wire uart_echo_pkg::byte_t  rx_data
);

    // Receiver to FSM
    wire                              rx_valid;
    wire uart_echo_pkg::rx_byte_t     rx_byte;

    // FSM and line memory
    wire uart_echo_pkg::line_wr_t     line_wr;
    wire uart_echo_pkg::line_addr_t   rd_addr;
    wire uart_echo_pkg::byte_t        rd_data;
    wire uart_echo_pkg::line_len_t    line_len;

    // FSM to transmitter
    wire                              tx_start;
    wire uart_echo_pkg::byte_t        tx_data;
    wire                              tx_busy;

    uart_rx ins_uart_rx (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_port (uart_rx_port),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte)
    );

    line_buffer ins_line_buffer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .line_wr   (line_wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .line_len  (line_len)
    );

    // Owns the gap timer
    line_echo_fsm ins_line_echo_fsm (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .line_len  (line_len),
        .rd_data   (rd_data),
        .tx_busy   (tx_busy),
        .line_wr   (line_wr),
        .rd_addr   (rd_addr),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .rx_data   (rx_data)
    );

    uart_tx ins_uart_tx (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .tx_busy      (tx_busy),
        .uart_tx_port (uart_tx_port)
    );

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
// 8N1 serial receiver, input is asynchronous
// No parity, one stop bit; bad stop bit flags frame_err
// rx_byte is only meaningful while rx_valid is high
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  wire                     sys_clk,
    input  wire                     sys_rst_n,
    input  wire                     uart_rx_port,
    output logic                    rx_valid,
    output uart_echo_pkg::rx_byte_t rx_byte
);

    // Synchroniser and edge history
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic start_edge;

    // Frame progress
    logic                    run;
    logic                    mid;
    uart_echo_pkg::bit_idx_t bit_idx;
    uart_echo_pkg::byte_t    shift_reg;

    bit_timer ins_rx_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .run       (run),
        .tick      (),
        .mid       (mid)
    );

    // Two flops into the clock domain, line idles high
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx_port;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Falling edge starts a frame
    assign start_edge = rx_prev & ~rx_sync;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            run      <= 1'b0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!run) begin
                if (start_edge) begin
                    run     <= 1'b1;
                    bit_idx <= '0;
                end
            end else if (mid) begin
                if (bit_idx == '0 && rx_sync) begin
                    // Glitch, start bit gone high again
                    run <= 1'b0;
                end else if (bit_idx == uart_echo_pkg::STOP_IDX) begin
                    // Stop bit sampled, hand off the byte
                    run      <= 1'b0;
                    rx_valid <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge sys_clk) begin
        if (run && mid) begin
            if (bit_idx == uart_echo_pkg::STOP_IDX) begin
                rx_byte.data      <= shift_reg;
                rx_byte.frame_err <= ~rx_sync;
            end else if (bit_idx != '0) begin
                shift_reg <= {rx_sync, shift_reg[7:1]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// 8N1 serial transmitter, one byte per tx_start
// tx_start is ignored while tx_busy is high
// One frame keeps tx_busy high for 10 bit periods
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  wire                  sys_clk,
    input  wire                  sys_rst_n,
    input  wire                  tx_start,
    input  wire uart_echo_pkg::byte_t tx_data,
    output logic                 tx_busy,
    output logic                 uart_tx_port
);

    logic                    tick;
    uart_echo_pkg::bit_idx_t bit_idx;
    // Data bits then stop bit, start bit goes out directly
    logic [8:0]              shift_reg;

    // Timer runs for exactly the busy window
    bit_timer ins_tx_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .run       (tx_busy),
        .tick      (tick),
        .mid       ()
    );

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            tx_busy      <= 1'b0;
            uart_tx_port <= 1'b1;
            bit_idx      <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Start bit begins with busy
                tx_busy      <= 1'b1;
                uart_tx_port <= 1'b0;
                bit_idx      <= '0;
            end
        end else if (tick) begin
            if (bit_idx == uart_echo_pkg::STOP_IDX) begin
                // End of stop bit
                tx_busy      <= 1'b0;
                uart_tx_port <= 1'b1;
            end else begin
                uart_tx_port <= shift_reg[0];
                bit_idx      <= bit_idx + 1'b1;
            end
        end
    end

    // Shifter fills with ones so the last bit out is the stop bit
    always_ff @(posedge sys_clk) begin
        if (!tx_busy && tx_start) begin
            shift_reg <= {1'b1, tx_data};
        end else if (tx_busy && tick) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
hw/uart_echo_pkg.sv
hw/bit_timer.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/line_buffer.sv
hw/line_echo_fsm.sv
hw/uart_echo_top.sv
tb/uart_echo_tb.sv

// ==== tb/uart_serial_bfm.svh ====
// Serial frame driver and monitor for 8N1 at the package baud
// Included inside the testbench module, uses its signals, queues and counters
// The driver runs on falling clock edges only
`ifndef UART_SERIAL_BFM_SVH
`define UART_SERIAL_BFM_SVH

    // One 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One frame on uart_rx_port, LSB first, stop bit level chosen by caller
    task automatic drive_frame(input uart_echo_pkg::byte_t data, input logic stop_good);
        int i;
        @(negedge sys_clk);
        // Start bit
        uart_rx_port = 1'b0;
        repeat (uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
        for (i = 0; i < 8; i++) begin
            uart_rx_port = data[i];
            repeat (uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
        end
        // Stop bit, low for a framing error
        uart_rx_port = stop_good;
        repeat (uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
        uart_rx_port = 1'b1;
        // After a low stop bit the next start edge needs an idle bit first
        if (!stop_good) begin
            repeat (uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
        end
    endtask

    // Watches uart_tx_port forever and queues each byte
    // Samples at mid-bit, half a cycle away from the DUT edges
    task automatic capture_frames();
        uart_echo_pkg::byte_t data;
        int i;
        forever begin
            @(negedge sys_clk);
            if (uart_tx_port === 1'b0) begin
                repeat (uart_echo_pkg::HALF_CYCLES) @(negedge sys_clk);
                // Start bit still low at mid-bit
                if (uart_tx_port === 1'b0) begin
                    for (i = 0; i < 8; i++) begin
                        repeat (uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
                        data[i] = uart_tx_port;
                    end
                    repeat (uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
                    if (uart_tx_port !== 1'b1) begin
                        $display("Stop bit on uart_tx_port was not high in %s", cur_test);
                        err_count++;
                    end
                    cap_queue.push_back(data);
                end
            end
        end
    endtask

`endif

// ==== tb/uart_echo_tb.sv ====
// Self-checking testbench for the UART line echo, random data from a fixed seed
// Real serial timing at the package baud, roughly 40 ms of simulated time
// Lines are closed by idling the input well past the gap limit
`timescale 1ns/1ns
`default_nettype none

module uart_echo_tb;

    // Worst case frame counts over all tests, sent and echoed
    localparam int LINES_RAND = 12;
    localparam int SENT_MAX   = 2 + LINES_RAND * 20 + 130 + 8;
    localparam int ECHO_MAX   = 4 + LINES_RAND * 22 + 130 + 6;
    localparam longint FRAME_NS    = 10 * uart_echo_pkg::BIT_CYCLES * 10;
    localparam longint WATCHDOG_NS = (SENT_MAX + ECHO_MAX) * FRAME_NS * 2;
    // Frames with a low stop bit in the framing test, last one included
    localparam logic [7:0] BAD_MASK = 8'b1001_1010;
    // Idle bit times after an echo before its result is judged
    localparam int SETTLE_BITS = 15;

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic                 uart_rx_port;
    logic                 uart_tx_port;
    uart_echo_pkg::byte_t rx_data;

    // Bytes captured from the transmit line
    uart_echo_pkg::byte_t cap_queue[$];
    // Reference model, open line and expected echo
    uart_echo_pkg::byte_t line_q[$];
    uart_echo_pkg::byte_t exp_queue[$];
    uart_echo_pkg::byte_t exp_rx_data;
    logic                 echoing;

    logic [31:0] rng_state;
    string       cur_test;
    int          err_count;
    int          test_errs;
    int          pass_count;
    int          fail_count;

    uart_echo_top uart_echo_top_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port),
        .rx_data      (rx_data)
    );

    // 10 ns period
    always #5 sys_clk = ~sys_clk;

    `include "uart_serial_bfm.svh"

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_byte(input string what, input uart_echo_pkg::byte_t exp,
                              input uart_echo_pkg::byte_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_len(input string what, input uart_echo_pkg::line_len_t exp,
                             input uart_echo_pkg::line_len_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", what, exp, act);
            err_count++;
        end
    endtask

    // Line closes into the expected echo with CR LF
    function automatic void close_line();
        if (line_q.size() != 0) begin
            foreach (line_q[i]) begin
                exp_queue.push_back(line_q[i]);
            end
            exp_queue.push_back(8'h0D);
            exp_queue.push_back(8'h0A);
            line_q.delete();
            echoing = 1'b1;
        end
    endfunction

    // Good bytes join the open line, nothing is taken during an echo
    task automatic send_byte(input uart_echo_pkg::byte_t data, input logic good);
        drive_frame(data, good);
        if (good && !echoing) begin
            line_q.push_back(data);
            exp_rx_data = data;
            if (line_q.size() == uart_echo_pkg::LINE_MAX) begin
                close_line();
            end
        end
    endtask

    // Idle until the echo is in, then compare it byte for byte
    task automatic finish_line();
        int waited;
        int limit;
        int n;
        int i;
        close_line();
        waited = 0;
        limit = (exp_queue.size() * 10 + 40) * uart_echo_pkg::BIT_CYCLES;
        while (cap_queue.size() < exp_queue.size() && waited < limit) begin
            @(negedge sys_clk);
            waited++;
        end
        if (cap_queue.size() < exp_queue.size()) begin
            $display("Timed out waiting for the echo in %s", cur_test);
            err_count++;
        end
        // Lets the LF frame end and shows any extra frame
        repeat (SETTLE_BITS * uart_echo_pkg::BIT_CYCLES) @(negedge sys_clk);
        check_len({cur_test, " echo length"}, uart_echo_pkg::line_len_t'(exp_queue.size()),
                  uart_echo_pkg::line_len_t'(cap_queue.size()));
        n = (cap_queue.size() < exp_queue.size()) ? cap_queue.size() : exp_queue.size();
        for (i = 0; i < n; i++) begin
            check_byte($sformatf("%s echo byte %0d", cur_test, i), exp_queue[i], cap_queue[i]);
        end
        check_byte({cur_test, " rx_data"}, exp_rx_data, rx_data);
        exp_queue.delete();
        cap_queue.delete();
        echoing = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge sys_clk);
        sys_rst_n = 1'b0;
        repeat (8) @(negedge sys_clk);
        sys_rst_n = 1'b1;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_errs) begin
            pass_count++;
            $display("PASS %s", cur_test);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", cur_test, err_count - test_errs);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          len;
        int          ln;
        int          k;
        logic        tx_level;
        sys_clk      = 1'b0;
        sys_rst_n    = 1'b0;
        uart_rx_port = 1'b1;
        rng_state    = 32'h90ba_4ab3;
        exp_rx_data  = 8'h00;
        echoing      = 1'b0;
        err_count    = 0;
        pass_count   = 0;
        fail_count   = 0;
        cur_test     = "reset";
        apply_reset();
        fork
            capture_frames();
        join_none

        begin_test("hi_line");
        send_byte("h", 1'b1);
        send_byte("i", 1'b1);
        finish_line();
        end_test();

        begin_test("random_lines");
        for (ln = 0; ln < LINES_RAND; ln++) begin
            r = rand_next();
            len = 1 + int'(r % 20);
            for (k = 0; k < len; k++) begin
                r = rand_next();
                send_byte(r[7:0], 1'b1);
            end
            finish_line();
        end
        end_test();

        // Bytes 129 and 130 land while the echo runs
        begin_test("full_line");
        for (k = 0; k < 130; k++) begin
            r = rand_next();
            send_byte(r[7:0], 1'b1);
        end
        finish_line();
        end_test();

        begin_test("framing_errors");
        for (k = 0; k < 8; k++) begin
            r = rand_next();
            send_byte(r[7:0], !BAD_MASK[k]);
        end
        finish_line();
        end_test();

        begin_test("idle_after_reset");
        apply_reset();
        line_q.delete();
        exp_queue.delete();
        cap_queue.delete();
        exp_rx_data = 8'h00;
        echoing = 1'b0;
        check_byte("idle_after_reset rx_data", exp_rx_data, rx_data);
        // Any non-high sample is kept
        tx_level = 1'b1;
        repeat (40 * uart_echo_pkg::BIT_CYCLES) begin
            @(negedge sys_clk);
            if (uart_tx_port !== 1'b1) begin
                tx_level = uart_tx_port;
            end
        end
        check_level("idle_after_reset uart_tx_port", 1'b1, tx_level);
        check_len("idle_after_reset frames", 8'd0, uart_echo_pkg::line_len_t'(cap_queue.size()));
        end_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, twice the worst case serial traffic
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired in %s before the tests finished", cur_test);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
